//--- mat_pkg.sv
// shared element and mode types for the matrix engine
// elements are unsigned integers
// products and sums keep only the low elem_w bits
package mat_pkg;

	localparam int elem_w = 27; // element and product width

	// one matrix element or one product term
	typedef logic [elem_w-1:0] elem_t;

	// arithmetic mode, latched by the engine at start
	typedef enum logic {
		par_mode, // element-wise products
		mat_mode  // accumulated outer products, a times b
	} mode_t;

	// operand matrix targeted by a load
	typedef enum logic {
		sel_a,
		sel_b
	} bank_sel_t;

endpackage

//--- mult_array.sv
// n x n array of multipliers, one registered product per cell
// latency is one enabled cycle, products truncated to elem_w bits
// outputs are undefined until inputs have been clocked in once
`timescale 1ns/1ps

module mult_array #(
	parameter int n = 6
) (
	input logic i,
	input logic en,
	input mat_pkg::elem_t [n-1:0][n-1:0] dataa,
	input mat_pkg::elem_t [n-1:0][n-1:0] datab,
	output mat_pkg::elem_t [n-1:0][n-1:0] product
);

	mat_pkg::elem_t cell_q [n][n]; // per-cell product register

	for (genvar r = 0; r < n; r++) begin : g_row
		for (genvar c = 0; c < n; c++) begin : g_col
			always_ff @(posedge i) begin
				if (en) begin
					cell_q[r][c] <= mat_pkg::elem_t'(dataa[r][c] * datab[r][c]); // low bits kept
				end
			end
		end
	end

	// gather cells onto the matrix bus
	always_comb begin
		for (int r = 0; r < n; r++) begin
			for (int c = 0; c < n; c++) begin
				product[r][c] = cell_q[r][c];
			end
		end
	end

endmodule

//--- operand_bank.sv
// live a and b matrices loaded one element per write, plus the snapshot
// copy that feeds the engine
// a load in the start cycle goes to the live store only
// out-of-range row or column addresses are dropped
// nothing changes state while en is low
`timescale 1ns/1ps

module operand_bank #(
	parameter int n = 6,
	localparam int aw = (n > 1) ? $clog2(n) : 1
) (
	input logic i,
	input logic reset,
	input logic en,
	input logic load_we,
	input mat_pkg::bank_sel_t load_sel,
	input logic [aw-1:0] load_row,
	input logic [aw-1:0] load_col,
	input mat_pkg::elem_t load_data,
	input logic start,
	output mat_pkg::elem_t [n-1:0][n-1:0] op_a,
	output mat_pkg::elem_t [n-1:0][n-1:0] op_b,
	output logic go
);

	mat_pkg::elem_t [n-1:0][n-1:0] live_a;
	mat_pkg::elem_t [n-1:0][n-1:0] live_b;
	logic in_range;

	assign in_range = (int'(load_row) < n) && (int'(load_col) < n);

	// element writes into the live store
	always_ff @(posedge i) begin
		if (en && load_we && in_range) begin
			case (load_sel)
				mat_pkg::sel_a: live_a[load_row][load_col] <= load_data;
				mat_pkg::sel_b: live_b[load_row][load_col] <= load_data;
			endcase
		end
	end

	// snapshot takes the pre-write contents on start
	always_ff @(posedge i) begin
		if (en && start) begin
			op_a <= live_a;
			op_b <= live_b;
		end
	end

	always_ff @(posedge i) begin
		if (reset) begin
			go <= 1'b0;
		end else if (en) begin
			go <= start; // one enabled cycle, aligned with the snapshot
		end
	end

endmodule

//--- mat_mult.sv
// n x n multiply engine with parallel and matrix modes
// parallel result 3 enabled cycles after go, matrix result after n+2
// a go while busy is dropped, op_a and op_b must hold until result_valid
// result keeps its value between result_valid pulses
`timescale 1ns/1ps

module mat_mult #(
	parameter int n = 6
) (
	input logic i,
	input logic reset,
	input logic en,
	input logic go,
	input mat_pkg::mode_t mode,
	input mat_pkg::elem_t [n-1:0][n-1:0] op_a,
	input mat_pkg::elem_t [n-1:0][n-1:0] op_b,
	output mat_pkg::elem_t [n-1:0][n-1:0] result,
	output logic result_valid,
	output logic busy
);

	localparam int step_w = (n > 1) ? $clog2(n) : 1;

	typedef logic [step_w-1:0] step_t;
	typedef enum logic [1:0] {idle, feed, drain, done} state_t;

	state_t state;
	mat_pkg::mode_t mode_q; // mode latched on go
	step_t cnt;             // step being fed
	step_t last_step;
	step_t in_step;         // step at the multiplier inputs
	step_t prod_step;       // step of the products leaving the array
	logic in_vld;
	logic prod_vld;
	logic last_term;
	mat_pkg::elem_t [n-1:0][n-1:0] mult_a;
	mat_pkg::elem_t [n-1:0][n-1:0] mult_b;
	mat_pkg::elem_t [n-1:0][n-1:0] product;
	mat_pkg::elem_t [n-1:0][n-1:0] acc;
	mat_pkg::elem_t [n-1:0][n-1:0] acc_sum;

	mult_array #(
		.n(n)
	) mults (
		.i(i),
		.en(en),
		.dataa(mult_a),
		.datab(mult_b),
		.product(product)
	);

	// parallel mode is a single term
	assign last_step = (mode_q == mat_pkg::mat_mode) ? step_t'(n - 1) : '0;
	assign last_term = prod_vld && (prod_step == last_step);
	assign busy = (state == feed) || (state == drain);
	assign result_valid = (state == done);

	always_ff @(posedge i) begin
		if (reset) begin
			state <= idle;
			mode_q <= mat_pkg::par_mode;
			cnt <= '0;
		end else if (en) begin
			case (state)
				idle, done: begin
					if (go) begin
						mode_q <= mode;
						cnt <= '0;
						state <= feed;
					end else begin
						state <= idle;
					end
				end
				feed: begin
					if (cnt == last_step) begin
						state <= drain;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				drain: begin
					if (last_term) begin
						state <= done; // busy drops as result_valid rises
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// multiplier input selection for the current step
	always_ff @(posedge i) begin
		if (en && state == feed) begin
			for (int r = 0; r < n; r++) begin
				for (int c = 0; c < n; c++) begin
					if (mode_q == mat_pkg::mat_mode) begin
						mult_a[r][c] <= op_a[r][cnt]; // column cnt of a along each row
						mult_b[r][c] <= op_b[cnt][c]; // row cnt of b down each column
					end else begin
						mult_a[r][c] <= op_a[r][c];
						mult_b[r][c] <= op_b[r][c];
					end
				end
			end
		end
	end

	// step tag follows the operands through the multiplier stage
	always_ff @(posedge i) begin
		if (reset) begin
			in_vld <= 1'b0;
			prod_vld <= 1'b0;
			in_step <= '0;
			prod_step <= '0;
		end else if (en) begin
			in_vld <= (state == feed);
			in_step <= cnt;
			prod_vld <= in_vld;
			prod_step <= in_step;
		end
	end

	// first term loads, later terms add, wrapping at elem_w bits
	always_comb begin
		for (int r = 0; r < n; r++) begin
			for (int c = 0; c < n; c++) begin
				acc_sum[r][c] = product[r][c];
				if (prod_step != '0) begin
					acc_sum[r][c] = acc[r][c] + product[r][c];
				end
			end
		end
	end

	always_ff @(posedge i) begin
		if (en && prod_vld) begin
			acc <= acc_sum;
		end
	end

	always_ff @(posedge i) begin
		if (reset) begin
			result <= '0;
		end else if (en && last_term) begin
			result <= acc_sum; // full sum lands with result_valid
		end
	end

endmodule

//--- mat_engine.sv
// matrix engine top, operand bank in front of the multiply engine
// operands are loaded one element per write, start launches a run
// en low freezes every register, loads included
// issue start only when busy is low, a start during a run is dropped
`timescale 1ns/1ps

module mat_engine #(
	parameter int n = 6,
	localparam int aw = (n > 1) ? $clog2(n) : 1
) (
	input logic i,
	input logic reset,
	input logic en,
	input logic load_we,
	input mat_pkg::bank_sel_t load_sel,
	input logic [aw-1:0] load_row,
	input logic [aw-1:0] load_col,
	input mat_pkg::elem_t load_data,
	input mat_pkg::mode_t mode,
	input logic start,
	output mat_pkg::elem_t [n-1:0][n-1:0] result,
	output logic result_valid,
	output logic busy
);

	mat_pkg::elem_t [n-1:0][n-1:0] op_a; // snapshot taken at start
	mat_pkg::elem_t [n-1:0][n-1:0] op_b;
	logic go;

	operand_bank #(
		.n(n)
	) bank (
		.i(i),
		.reset(reset),
		.en(en),
		.load_we(load_we),
		.load_sel(load_sel),
		.load_row(load_row),
		.load_col(load_col),
		.load_data(load_data),
		.start(start),
		.op_a(op_a),
		.op_b(op_b),
		.go(go)
	);

	// mode is sampled one cycle after start, alongside go
	mat_mult #(
		.n(n)
	) engine (
		.i(i),
		.reset(reset),
		.en(en),
		.go(go),
		.mode(mode),
		.op_a(op_a),
		.op_b(op_b),
		.result(result),
		.result_valid(result_valid),
		.busy(busy)
	);

endmodule

//--- mat_engine_sva.sv
// output checks for mat_mult, attached to every instance by bind
// result_valid lasts one enabled cycle, en low freezes result
`timescale 1ns/1ps

module mat_engine_sva #(
	parameter int n = 6
) (
	input logic i,
	input logic reset,
	input logic en,
	input mat_pkg::elem_t [n-1:0][n-1:0] result,
	input logic result_valid,
	input logic busy
);

	int fail_cnt = 0; // failed assertion count

	valid_one_cycle: assert property (@(posedge i) disable iff (reset)
		result_valid && en |=> !result_valid)
	else begin
		fail_cnt++;
		$error("result_valid held past one enabled cycle");
	end

	reset_quiet: assert property (@(posedge i) reset |=> !result_valid && !busy)
	else begin
		fail_cnt++;
		$error("result_valid or busy high during reset");
	end

	stall_frozen: assert property (@(posedge i) disable iff (reset) !en |=> $stable(result))
	else begin
		fail_cnt++;
		$error("result changed while en was low");
	end

	valid_after_busy: assert property (@(posedge i) disable iff (reset)
		$rose(result_valid) |-> $past(busy))
	else begin
		fail_cnt++;
		$error("result_valid without busy in the cycle before");
	end

endmodule

bind mat_mult mat_engine_sva #(.n(n)) sva (
	.i(i),
	.reset(reset),
	.en(en),
	.result(result),
	.result_valid(result_valid),
	.busy(busy)
);

//--- tb_mat_engine.sv
// drives mat_engine with n = 6 from the cases in mat_engine_vectors.txt
// run from the project root so the vector file is found
// each case's operands are loaded while the previous case runs
`timescale 1ns/1ps

module tb_mat_engine;

	localparam int n = 6;
	localparam int max_cases = 8;

	logic i;
	logic reset;
	logic en;
	logic load_we;
	mat_pkg::bank_sel_t load_sel;
	logic [2:0] load_row;
	logic [2:0] load_col;
	mat_pkg::elem_t load_data;
	mat_pkg::mode_t mode;
	logic start;
	mat_pkg::elem_t [n-1:0][n-1:0] result;
	logic result_valid;
	logic busy;

	string name_v [max_cases];
	mat_pkg::mode_t mode_v [max_cases];
	logic stall_v [max_cases];
	mat_pkg::elem_t a_v [max_cases][n*n];
	mat_pkg::elem_t b_v [max_cases][n*n];
	mat_pkg::elem_t exp_v [max_cases][n*n];
	mat_pkg::elem_t [n-1:0][n-1:0] got_res; // captured at the last valid pulse
	int ncases = 0;
	int errors = 0;
	int valid_cnt = 0;
	int starts = 0;
	int seed;
	logic stalling = 1'b0;
	logic vectors_read = 1'b0;

	mat_engine #(
		.n(n)
	) uut (
		.i(i),
		.reset(reset),
		.en(en),
		.load_we(load_we),
		.load_sel(load_sel),
		.load_row(load_row),
		.load_col(load_col),
		.load_data(load_data),
		.mode(mode),
		.start(start),
		.result(result),
		.result_valid(result_valid),
		.busy(busy)
	);

	initial begin
		i = 1'b0;
		forever #2 i = ~i;
	end

	// en seen at negedge is the value for the coming edge
	always @(negedge i) begin
		if (result_valid && en) begin
			valid_cnt++;
			got_res = result;
		end
	end

	task automatic read_vectors();
		int fd;
		int cnt;
		int row;
		int md;
		int st;
		int j;
		string line;
		string nm;
		logic [31:0] v [6];
		row = 3 * n;
		fd = $fopen("mat_engine_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open mat_engine_vectors.txt");
			errors++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.getc(0) != "#") begin
				if (row == 3 * n) begin
					cnt = $sscanf(line, "%s %d %d", nm, md, st);
					if (cnt != 3 || ncases >= max_cases) begin
						$display("bad or surplus case header in vector file: %s", line);
						errors++;
						break;
					end
					name_v[ncases] = nm;
					mode_v[ncases] = (md != 0) ? mat_pkg::mat_mode : mat_pkg::par_mode;
					stall_v[ncases] = (st != 0);
					row = 0;
				end else begin
					cnt = $sscanf(line, "%h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5]);
					if (cnt != n) begin
						$display("bad data row in vector file: %s", line);
						errors++;
						break;
					end
					for (j = 0; j < n; j++) begin
						case (row / n)
							0: a_v[ncases][(row % n) * n + j] = mat_pkg::elem_t'(v[j]);
							1: b_v[ncases][(row % n) * n + j] = mat_pkg::elem_t'(v[j]);
							default: exp_v[ncases][(row % n) * n + j] = mat_pkg::elem_t'(v[j]);
						endcase
					end
					row++;
					if (row == 3 * n) ncases++;
				end
			end
		end
		$fclose(fd);
		if (row != 3 * n) begin
			$display("vector file ends inside a case");
			errors++;
		end
		if (ncases == 0) begin
			$display("no test cases found in vector file");
			errors++;
		end
	endtask

	task automatic pick_en();
		if (stalling) begin
			en = (($random(seed) & 3) != 0); // low about one cycle in four
		end else begin
			en = 1'b1;
		end
	endtask

	task automatic idle_cycle();
		pick_en();
		@(posedge i);
		#1;
	endtask

	// repeat until an edge with en high has taken the inputs
	task automatic wait_accept();
		do begin
			idle_cycle();
		end while (!en);
	endtask

	task automatic load_elem(input mat_pkg::bank_sel_t sel, input int r, input int c,
			input mat_pkg::elem_t d);
		load_we = 1'b1;
		load_sel = sel;
		load_row = 3'(r);
		load_col = 3'(c);
		load_data = d;
		wait_accept();
		load_we = 1'b0;
	endtask

	task automatic load_case(input int k);
		int idx;
		for (idx = 0; idx < n * n; idx++) begin
			load_elem(mat_pkg::sel_a, idx / n, idx % n, a_v[k][idx]);
			load_elem(mat_pkg::sel_b, idx / n, idx % n, b_v[k][idx]);
		end
	endtask

	task automatic start_run(input mat_pkg::mode_t m);
		mode = m;
		start = 1'b1;
		wait_accept();
		start = 1'b0;
		wait_accept(); // engine takes go and mode here
		// the running case must keep its latched mode
		if (m == mat_pkg::par_mode) begin
			mode = mat_pkg::mat_mode;
		end else begin
			mode = mat_pkg::par_mode;
		end
		if (busy !== 1'b1) begin
			$display("busy did not rise after the run was launched");
			errors++;
		end
		starts++;
	endtask

	task automatic check_case(input int k);
		int idx;
		for (idx = 0; idx < n * n; idx++) begin
			if (got_res[idx / n][idx % n] !== exp_v[k][idx]) begin
				$display("FAIL %s elem %0d expected %h got %h", name_v[k], idx,
					exp_v[k][idx], got_res[idx / n][idx % n]);
				errors++;
			end
		end
		if (valid_cnt != starts) begin
			$display("case %s: %0d result pulses seen for %0d starts", name_v[k], valid_cnt, starts);
			errors++;
		end
		if (result !== got_res) begin
			$display("case %s: result changed after its valid pulse", name_v[k]);
			errors++;
		end
		if (busy !== 1'b0) begin
			$display("case %s: busy still high after the result", name_v[k]);
			errors++;
		end
	endtask

	initial begin
		wait (vectors_read);
		repeat (ncases * 200 + 100) @(posedge i);
		$display("run timed out after %0d cycles without finishing", ncases * 200 + 100);
		$display("Test failed");
		$finish;
	end

	initial begin
		int k;
		reset = 1'b1;
		en = 1'b1;
		load_we = 1'b0;
		load_sel = mat_pkg::sel_a;
		load_row = '0;
		load_col = '0;
		load_data = '0;
		mode = mat_pkg::par_mode;
		start = 1'b0;
		seed = 32'h1cf4;
		read_vectors();
		vectors_read = 1'b1;
		repeat (10) @(posedge i);
		#1;
		reset = 1'b0;
		if (ncases > 0) load_case(0);
		if (result !== '0) begin
			$display("result is not zero after reset");
			errors++;
		end
		if (busy !== 1'b0) begin
			$display("busy is high before the first start");
			errors++;
		end
		if (valid_cnt != 0) begin
			$display("result_valid pulsed before the first start");
			errors++;
		end
		for (k = 0; k < ncases; k++) begin
			stalling = stall_v[k];
			start_run(mode_v[k]);
			if (k + 1 < ncases) load_case(k + 1); // new operands while running
			while (valid_cnt < starts) idle_cycle();
			repeat (n + 4) idle_cycle();
			check_case(k);
		end
		errors += uut.engine.sva.fail_cnt;
		$display("errors: %0d, result pulses: %0d, starts: %0d", errors, valid_cnt, starts);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- mat_engine.f
mat_pkg.sv
mult_array.sv
operand_bank.sv
mat_mult.sv
mat_engine.sv
mat_engine_sva.sv
tb_mat_engine.sv

//--- run.sh
#!/bin/sh
# compile and run the matrix engine testbench with verilator
# paths are relative to the project root, so work from there
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mat_engine \
	-f mat_engine.f -o tb_mat_engine
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

out=$(./obj_dir/tb_mat_engine)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
	exit 0
fi
exit 1

//--- mat_engine_vectors.txt
# header line: case name, mode (0 parallel, 1 matrix), stall flag (0 or 1)
# then six rows of a, six rows of b, six rows of the expected result, all hex
par_trunc 0 0
1 2 3 4 5 6
7 8 9 a b c
10 20 30 40 50 60
7ffffff 4000000 100 3 0 1
1234 fff 2 5 7ffffff abc
0 1 2 3 4 5
2 3 4 5 6 7
1 1 1 1 1 1
3 3 3 3 3 3
7ffffff 2 10000 5 1234567 5555555
10 1000 3 7 2 1
9 9 9 9 9 9
2 6 c 14 1e 2a
7 8 9 a b c
30 60 90 c0 f0 120
1 0 1000000 f 0 5555555
12340 fff000 6 23 7fffffe abc
0 9 12 1b 24 2d
mat_ident 1 0
1 2 3 4 5 6
10 11 12 13 14 15
7ffffff 0 abcdef 1 2 3
100 200 300 400 500 600
5a5a5a5 2a5a5a5 0 0 1 1
6 5 4 3 2 1
1 0 0 0 0 0
0 1 0 0 0 0
0 0 1 0 0 0
0 0 0 1 0 0
0 0 0 0 1 0
0 0 0 0 0 1
1 2 3 4 5 6
10 11 12 13 14 15
7ffffff 0 abcdef 1 2 3
100 200 300 400 500 600
5a5a5a5 2a5a5a5 0 0 1 1
6 5 4 3 2 1
mat_full 1 1
7ffffff 7ffffff 7ffffff 7ffffff 7ffffff 7ffffff
7ffffff 7ffffff 7ffffff 7ffffff 7ffffff 7ffffff
7ffffff 7ffffff 7ffffff 7ffffff 7ffffff 7ffffff
7ffffff 7ffffff 7ffffff 7ffffff 7ffffff 7ffffff
7ffffff 7ffffff 7ffffff 7ffffff 7ffffff 7ffffff
7ffffff 7ffffff 7ffffff 7ffffff 7ffffff 7ffffff
1 2 3 4 5 6
2 3 4 5 6 7
3 4 5 6 7 8
4 5 6 7 8 9
5 6 7 8 9 a
6 7 8 9 a b
7ffffeb 7ffffe5 7ffffdf 7ffffd9 7ffffd3 7ffffcd
7ffffeb 7ffffe5 7ffffdf 7ffffd9 7ffffd3 7ffffcd
7ffffeb 7ffffe5 7ffffdf 7ffffd9 7ffffd3 7ffffcd
7ffffeb 7ffffe5 7ffffdf 7ffffd9 7ffffd3 7ffffcd
7ffffeb 7ffffe5 7ffffdf 7ffffd9 7ffffd3 7ffffcd
7ffffeb 7ffffe5 7ffffdf 7ffffd9 7ffffd3 7ffffcd
mat_shift 1 1
1 2 3 4 5 6
7 8 9 a b c
d e f 10 11 12
100 0 0 0 0 200
3ffffff 0 0 0 0 4000000
0 0 0 0 0 1
1 2 0 0 0 0
0 1 2 0 0 0
0 0 1 2 0 0
0 0 0 1 2 0
0 0 0 0 1 2
2 0 0 0 0 1
d 4 7 a d 10
1f 16 19 1c 1f 22
31 28 2b 2e 31 34
500 200 0 0 0 200
3ffffff 7fffffe 0 0 0 4000000
2 0 0 0 0 1
